//--- project.f
source/eu_pkg.sv
source/eu_reg_port.sv
source/eu_event_regs.sv
source/eu_irq_select.sv
source/eu_clock_fsm.sv
source/event_unit_top.sv
sim/tb_event_unit.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the event unit testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_event_unit \
  --Mdir obj_dir \
  -f project.f

# a failing check ends in $fatal, which gives a non-zero exit status
./obj_dir/Vtb_event_unit

//--- sim/tb_event_unit.sv
// testbench for the event unit: drives register port, event lines and acks, checks against a model
`timescale 1ns/1ps
`default_nettype none

module tb_event_unit;

  localparam int unsigned NB_EVENTS  = 32;
  localparam int unsigned ID_W       = $clog2(NB_EVENTS);
  // about 60 accesses of under 10 cycles each plus the sleep waits, so a wide margin
  localparam int unsigned MAX_CYCLES = 2000;
  localparam int unsigned MAX_WAIT   = 20;

  logic                      clk_i;
  logic                      rst_ni;
  logic                      req_i;
  logic                      wen_i;
  logic [eu_pkg::OFFS_W-1:0] addr_i;
  logic [eu_pkg::DATA_W-1:0] wdata_i;
  logic                      gnt_o;
  logic                      r_valid_o;
  logic [eu_pkg::DATA_W-1:0] r_rdata_o;
  logic [NB_EVENTS-1:0]      event_lines_i;
  logic                      irq_req_o;
  logic [ID_W-1:0]           irq_id_o;
  logic                      irq_ack_i;
  logic [ID_W-1:0]           irq_ack_id_i;
  logic                      core_busy_i;
  logic                      core_clock_en_o;

  integer                    seed;
  int unsigned               cycles = 0;
  logic [eu_pkg::DATA_W-1:0] rnd;
  // reference model of masks and buffer
  logic [NB_EVENTS-1:0]      m_evt_mask;
  logic [NB_EVENTS-1:0]      m_irq_mask;
  logic [NB_EVENTS-1:0]      m_evt_buf;
  logic [eu_pkg::DATA_W-1:0] rd_exp_q;
  // high in the cycle after the testbench saw its request accepted
  logic                      rsp_exp_q;
  logic                      irq_chk_q;
  logic [ID_W-1:0]           irq_exp_q;

  event_unit_top #(.NB_EVENTS(NB_EVENTS)) DUT (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .req_i           (req_i),
    .wen_i           (wen_i),
    .addr_i          (addr_i),
    .wdata_i         (wdata_i),
    .gnt_o           (gnt_o),
    .r_valid_o       (r_valid_o),
    .r_rdata_o       (r_rdata_o),
    .event_lines_i   (event_lines_i),
    .irq_req_o       (irq_req_o),
    .irq_id_o        (irq_id_o),
    .irq_ack_i       (irq_ack_i),
    .irq_ack_id_i    (irq_ack_id_i),
    .core_busy_i     (core_busy_i),
    .core_clock_en_o (core_clock_en_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("*** TEST FAILED ***");
    $fatal(1);
  endtask

  // register contents as the register map describes them
  function automatic logic [eu_pkg::DATA_W-1:0] read_value(
    input logic [eu_pkg::OFFS_W-1:0] offs
  );
    logic [eu_pkg::DATA_W-1:0] v;
    v = '0;
    case (eu_pkg::eu_reg_e'(offs))
      eu_pkg::REG_EVT_MASK:       v[NB_EVENTS-1:0] = m_evt_mask;
      eu_pkg::REG_IRQ_MASK:       v[NB_EVENTS-1:0] = m_irq_mask;
      // reads are only made while the core runs
      eu_pkg::REG_CLK_STATUS:     v[0] = 1'b1;
      eu_pkg::REG_EVT_BUF:        v[NB_EVENTS-1:0] = m_evt_buf;
      eu_pkg::REG_EVT_BUF_MASKED,
      eu_pkg::REG_WAIT,
      eu_pkg::REG_WAIT_CLR:       v[NB_EVENTS-1:0] = m_evt_buf & m_evt_mask;
      eu_pkg::REG_IRQ_BUF_MASKED: v[NB_EVENTS-1:0] = m_evt_buf & m_irq_mask;
      default:                    v = '0;
    endcase
    return v;
  endfunction

  // search down from the top bit, first hit wins
  function automatic logic [ID_W-1:0] top_index(input logic [NB_EVENTS-1:0] v);
    logic [ID_W-1:0] idx;
    logic            found;
    idx   = '0;
    found = 1'b0;
    for (int i = NB_EVENTS - 1; i >= 0; i--) begin
      if (!found && v[i]) begin
        idx   = ID_W'(i);
        found = 1'b1;
      end
    end
    return idx;
  endfunction

  task automatic model_write(
    input logic [eu_pkg::OFFS_W-1:0] offs,
    input logic [NB_EVENTS-1:0]      d
  );
    case (eu_pkg::eu_reg_e'(offs))
      eu_pkg::REG_EVT_MASK:     m_evt_mask = d;
      eu_pkg::REG_EVT_MASK_CLR: m_evt_mask = m_evt_mask & ~d;
      eu_pkg::REG_EVT_MASK_SET: m_evt_mask = m_evt_mask | d;
      eu_pkg::REG_IRQ_MASK:     m_irq_mask = d;
      eu_pkg::REG_IRQ_MASK_CLR: m_irq_mask = m_irq_mask & ~d;
      eu_pkg::REG_IRQ_MASK_SET: m_irq_mask = m_irq_mask | d;
      eu_pkg::REG_EVT_BUF_CLR:  m_evt_buf  = m_evt_buf & ~d;
      default: ;
    endcase
  endtask

  // all helpers return at a falling edge, where outputs are settled
  task automatic issue(
    input logic                      rd,
    input logic [eu_pkg::OFFS_W-1:0] offs,
    input logic [eu_pkg::DATA_W-1:0] d
  );
    @(posedge clk_i);
    req_i   <= 1'b1;
    wen_i   <= rd;
    addr_i  <= offs;
    wdata_i <= d;
    @(negedge clk_i);
  endtask

  task automatic complete(input logic at_once);
    int unsigned n;
    n = 0;
    if (at_once) begin
      assert (gnt_o) else stop_run($sformatf("Error: gnt_o = 0x%h, expected 0x1", gnt_o));
    end
    while (!gnt_o) begin
      if (n == MAX_WAIT) begin
        stop_run($sformatf("grant did not come within %0d cycles", MAX_WAIT));
      end
      n++;
      @(negedge clk_i);
    end
    // accepting edge
    @(posedge clk_i);
    req_i     <= 1'b0;
    rsp_exp_q <= 1'b1;
    if (wen_i) begin
      rd_exp_q <= read_value(addr_i);
      if (addr_i == eu_pkg::REG_WAIT_CLR) begin
        m_evt_buf = m_evt_buf & ~m_evt_mask;
      end
    end else begin
      rd_exp_q <= '0;
      model_write(addr_i, wdata_i[NB_EVENTS-1:0]);
    end
    // response cycle
    @(posedge clk_i);
    rsp_exp_q <= 1'b0;
    @(negedge clk_i);
  endtask

  task automatic access(
    input logic                      rd,
    input logic [eu_pkg::OFFS_W-1:0] offs,
    input logic [eu_pkg::DATA_W-1:0] d,
    input logic                      at_once
  );
    issue(rd, offs, d);
    complete(at_once);
  endtask

  task automatic read_reg(input logic [eu_pkg::OFFS_W-1:0] offs);
    access(1'b1, offs, '0, 1'b0);
  endtask

  task automatic write_reg(
    input logic [eu_pkg::OFFS_W-1:0] offs,
    input logic [eu_pkg::DATA_W-1:0] d
  );
    access(1'b0, offs, d, 1'b0);
  endtask

  // one-cycle pulse on the event lines
  task automatic pulse_events(input logic [NB_EVENTS-1:0] bits);
    @(posedge clk_i);
    event_lines_i <= bits;
    @(posedge clk_i);
    event_lines_i <= '0;
    m_evt_buf = m_evt_buf | bits;
    @(negedge clk_i);
  endtask

  task automatic ack_irq(input logic [ID_W-1:0] id);
    @(posedge clk_i);
    irq_ack_i    <= 1'b1;
    irq_ack_id_i <= id;
    @(posedge clk_i);
    irq_ack_i <= 1'b0;
    m_evt_buf[id] = 1'b0;
    @(negedge clk_i);
  endtask

  task automatic wait_clock_en(input logic level);
    int unsigned n;
    n = 0;
    while (core_clock_en_o != level) begin
      if (n == MAX_WAIT) begin
        stop_run($sformatf("core clock enable did not reach %0d in time", level));
      end
      n++;
      @(negedge clk_i);
    end
  endtask

  // opens a two-cycle window for the interrupt assertions
  task automatic check_irq(input logic [ID_W-1:0] id);
    @(posedge clk_i);
    irq_chk_q <= 1'b1;
    irq_exp_q <= id;
    repeat (2) @(posedge clk_i);
    irq_chk_q <= 1'b0;
    @(negedge clk_i);
  endtask

  a_rvalid : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
      r_valid_o == rsp_exp_q
  ) else stop_run($sformatf("Error: r_valid_o = 0x%h, expected 0x%h",
                            $sampled(r_valid_o), $sampled(rsp_exp_q)));

  a_rdata : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
      r_valid_o |-> r_rdata_o == rd_exp_q
  ) else stop_run($sformatf("Error: r_rdata_o = 0x%h, expected 0x%h",
                            $sampled(r_rdata_o), $sampled(rd_exp_q)));

  a_irq_req : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
      irq_chk_q |-> irq_req_o
  ) else stop_run($sformatf("Error: irq_req_o = 0x%h, expected 0x1", $sampled(irq_req_o)));

  a_irq_id : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
      irq_chk_q |-> irq_id_o == irq_exp_q
  ) else stop_run($sformatf("Error: irq_id_o = 0x%h, expected 0x%h",
                            $sampled(irq_id_o), $sampled(irq_exp_q)));

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      stop_run($sformatf("timeout, run did not end within %0d cycles", MAX_CYCLES));
    end
  end

  initial begin
    seed          = 32'h09ab_0705;
    rst_ni        = 1'b0;
    req_i         = 1'b0;
    wen_i         = 1'b0;
    addr_i        = '0;
    wdata_i       = '0;
    event_lines_i = '0;
    irq_ack_i     = 1'b0;
    irq_ack_id_i  = '0;
    core_busy_i   = 1'b0;
    m_evt_mask    = '0;
    m_irq_mask    = '0;
    m_evt_buf     = '0;
    rd_exp_q      = '0;
    rsp_exp_q     = 1'b0;
    irq_chk_q     = 1'b0;
    irq_exp_q     = '0;
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);

    // reset values, then mask writes with set and clear
    assert (core_clock_en_o && !irq_req_o)
      else stop_run("clock enable or interrupt request wrong after reset");
    for (int a = 0; a < 14; a++) begin
      read_reg(4'(a));
    end
    for (int b = 0; b < 6; b += 3) begin
      for (int k = 0; k < 3; k++) begin
        rnd = $random(seed);
        write_reg(4'(b + k), rnd);
        read_reg(4'(b));
      end
    end
    rnd = $random(seed);
    write_reg(4'd11, rnd);
    read_reg(eu_pkg::REG_EVT_MASK);
    read_reg(eu_pkg::REG_IRQ_MASK);

    // event capture and buffer clear
    repeat (3) begin
      rnd = $random(seed);
      pulse_events(rnd[NB_EVENTS-1:0]);
      read_reg(eu_pkg::REG_EVT_BUF);
      read_reg(eu_pkg::REG_EVT_BUF_MASKED);
      read_reg(eu_pkg::REG_IRQ_BUF_MASKED);
      rnd = $random(seed);
      write_reg(eu_pkg::REG_EVT_BUF_CLR, rnd);
      read_reg(eu_pkg::REG_EVT_BUF);
    end
    write_reg(eu_pkg::REG_IRQ_MASK, '0);

    // wait reads with an event already pending
    rnd = $random(seed);
    write_reg(eu_pkg::REG_EVT_MASK, rnd | 32'h1);
    rnd = $random(seed);
    pulse_events(rnd[NB_EVENTS-1:0] | 1);
    access(1'b1, eu_pkg::REG_WAIT, '0, 1'b1);
    access(1'b1, eu_pkg::REG_WAIT_CLR, '0, 1'b1);
    read_reg(eu_pkg::REG_EVT_BUF);

    // sleep until a masked event arrives
    write_reg(eu_pkg::REG_EVT_BUF_CLR, '1);
    write_reg(eu_pkg::REG_EVT_MASK, 32'h0000_0010);
    issue(1'b1, eu_pkg::REG_WAIT, '0);
    wait_clock_en(1'b0);
    assert (!gnt_o) else stop_run($sformatf("Error: gnt_o = 0x%h, expected 0x0", gnt_o));
    pulse_events(32'h0000_0210);
    wait_clock_en(1'b1);
    complete(1'b0);

    // interrupt priority and acknowledge
    rnd = $random(seed);
    write_reg(eu_pkg::REG_IRQ_MASK, rnd | 32'h1);
    repeat (3) begin
      rnd = $random(seed);
      pulse_events(rnd[NB_EVENTS-1:0] | 1);
      check_irq(top_index(m_evt_buf & m_irq_mask));
      ack_irq(top_index(m_evt_buf & m_irq_mask));
      read_reg(eu_pkg::REG_EVT_BUF);
    end

    // interrupt during sleep wakes the clock before the wait completes
    write_reg(eu_pkg::REG_IRQ_MASK, 32'h0000_0020);
    write_reg(eu_pkg::REG_EVT_MASK, 32'h0000_0008);
    write_reg(eu_pkg::REG_EVT_BUF_CLR, '1);
    issue(1'b1, eu_pkg::REG_WAIT, '0);
    wait_clock_en(1'b0);
    pulse_events(32'h0000_0028);
    assert (core_clock_en_o)
      else stop_run($sformatf("Error: core_clock_en_o = 0x%h, expected 0x1", core_clock_en_o));
    check_irq(5);
    assert (!gnt_o) else stop_run($sformatf("Error: gnt_o = 0x%h, expected 0x0", gnt_o));
    ack_irq(5);
    complete(1'b0);
    repeat (2) @(posedge clk_i);

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

//--- source/eu_clock_fsm.sv
// core clock gating FSM: stalls wait reads, gates the clock and decides wake-up
`timescale 1ns/1ps
`default_nettype none

module eu_clock_fsm (
  input  wire logic clk_i,
  input  wire logic rst_ni,
  input  wire logic sleep_req_i,
  input  wire logic wait_clr_i,
  input  wire logic evt_pending_i,
  input  wire logic irq_pending_i,
  input  wire logic irq_req_i,
  input  wire logic core_busy_i,
  output logic      stall_o,
  output logic      core_clock_en_o,
  output logic      clr_masked_o,
  output logic      irq_hold_o
);

  eu_pkg::clk_state_e state_q;
  eu_pkg::clk_state_e state_d;
  logic               irq_req_q;
  logic               hold_state;

  // a request already out toward the core is never withdrawn
  assign hold_state = (state_q == eu_pkg::ACTIVE) ||
                      (state_q == eu_pkg::WAKEUP_SLEEP) ||
                      (state_q == eu_pkg::WAKEUP_SLEEP_DEL);
  assign irq_hold_o = sleep_req_i & hold_state & ~irq_req_q;

  always_comb begin
    state_d         = state_q;
    stall_o         = 1'b0;
    core_clock_en_o = 1'b1;
    clr_masked_o    = 1'b0;

    case (state_q)
      eu_pkg::ACTIVE: begin
        if (sleep_req_i) begin
          if (evt_pending_i) begin
            // event already there, no need to sleep
            clr_masked_o = wait_clr_i;
            if (wait_clr_i) begin
              state_d = eu_pkg::WAKEUP_SLEEP_DEL;
            end
          end else if (irq_req_q) begin
            stall_o = 1'b1;
            state_d = eu_pkg::IRQ_WHILE_SLEEP;
          end else begin
            stall_o = 1'b1;
            if (!core_busy_i) begin
              state_d = eu_pkg::SLEEP;
            end
          end
        end
      end
      eu_pkg::SLEEP: begin
        core_clock_en_o = 1'b0;
        stall_o         = 1'b1;
        if (irq_pending_i) begin
          core_clock_en_o = 1'b1;
          state_d         = eu_pkg::WAKEUP_IRQ;
        end else if (evt_pending_i) begin
          state_d = eu_pkg::WAKEUP_SLEEP;
        end
      end
      eu_pkg::WAKEUP_SLEEP: begin
        // the held wait read is granted here
        clr_masked_o = wait_clr_i;
        if (wait_clr_i) begin
          state_d = eu_pkg::WAKEUP_SLEEP_DEL;
        end else begin
          state_d = eu_pkg::ACTIVE;
        end
      end
      eu_pkg::WAKEUP_SLEEP_DEL: begin
        // buffer clear still in flight, so hold off a new wait
        stall_o = sleep_req_i;
        state_d = eu_pkg::ACTIVE;
      end
      eu_pkg::WAKEUP_IRQ: begin
        stall_o = sleep_req_i;
        state_d = eu_pkg::IRQ_WHILE_SLEEP;
      end
      eu_pkg::IRQ_WHILE_SLEEP: begin
        if (sleep_req_i) begin
          if (irq_pending_i) begin
            stall_o = 1'b1;
          end else if (evt_pending_i) begin
            clr_masked_o = wait_clr_i;
            state_d      = wait_clr_i ? eu_pkg::WAKEUP_SLEEP_DEL : eu_pkg::ACTIVE;
          end else begin
            stall_o = 1'b1;
            if (!core_busy_i) begin
              state_d = eu_pkg::SLEEP;
            end
          end
        end else if (!irq_pending_i) begin
          state_d = eu_pkg::ACTIVE;
        end
      end
      default: begin
        state_d = eu_pkg::ACTIVE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= eu_pkg::ACTIVE;
      irq_req_q <= 1'b0;
    end else begin
      state_q   <= state_d;
      irq_req_q <= irq_req_i;
    end
  end

  a_clk_off_only_sleep : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
      !core_clock_en_o |-> (state_q == eu_pkg::SLEEP)
  );

  // a gated core never has an interrupt request outstanding
  a_no_irq_while_gated : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
      !core_clock_en_o |-> !irq_req_i
  );

endmodule

`default_nettype wire

//--- source/eu_event_regs.sv
// event mask, interrupt mask and event buffer registers with their write and clear updates
`timescale 1ns/1ps
`default_nettype none

module eu_event_regs #(
  parameter int unsigned NB_EVENTS = 32
) (
  input  wire logic                 clk_i,
  input  wire logic                 rst_ni,
  input  wire logic                 we_evt_mask_i,
  input  wire logic                 we_irq_mask_i,
  input  wire logic                 we_evt_buf_i,
  input  wire eu_pkg::eu_reg_e      wr_op_i,
  input  wire logic [NB_EVENTS-1:0] wdata_i,
  input  wire logic [NB_EVENTS-1:0] event_lines_i,
  input  wire logic                 clr_masked_i,
  input  wire logic [NB_EVENTS-1:0] clear_mask_i,
  output logic [NB_EVENTS-1:0]      evt_mask_o,
  output logic [NB_EVENTS-1:0]      irq_mask_o,
  output logic [NB_EVENTS-1:0]      evt_buf_o,
  output logic [NB_EVENTS-1:0]      evt_buf_masked_o,
  output logic                      evt_pending_o
);

  logic [NB_EVENTS-1:0] evt_mask_q;
  logic [NB_EVENTS-1:0] evt_mask_d;
  logic [NB_EVENTS-1:0] irq_mask_q;
  logic [NB_EVENTS-1:0] irq_mask_d;
  logic [NB_EVENTS-1:0] evt_buf_q;
  logic [NB_EVENTS-1:0] evt_buf_d;
  logic                 clr_masked_q;

  // plain write, or clear / set of the given bits
  function automatic logic [NB_EVENTS-1:0] mask_update(
    input logic [NB_EVENTS-1:0] cur,
    input logic [NB_EVENTS-1:0] wdat,
    input logic                 clr,
    input logic                 set
  );
    if (clr) begin
      return cur & ~wdat;
    end else if (set) begin
      return cur | wdat;
    end
    return wdat;
  endfunction

  always_comb begin
    evt_mask_d = evt_mask_q;
    irq_mask_d = irq_mask_q;
    if (we_evt_mask_i) begin
      evt_mask_d = mask_update(evt_mask_q, wdata_i,
                               wr_op_i == eu_pkg::REG_EVT_MASK_CLR,
                               wr_op_i == eu_pkg::REG_EVT_MASK_SET);
    end
    if (we_irq_mask_i) begin
      irq_mask_d = mask_update(irq_mask_q, wdata_i,
                               wr_op_i == eu_pkg::REG_IRQ_MASK_CLR,
                               wr_op_i == eu_pkg::REG_IRQ_MASK_SET);
    end
  end

  // wait_clear beats an explicit clear, new events are ORed in and the ack mask wins
  always_comb begin
    evt_buf_d = evt_buf_q;
    if (clr_masked_q) begin
      evt_buf_d = evt_buf_q & ~evt_mask_q;
    end else if (we_evt_buf_i) begin
      evt_buf_d = evt_buf_q & ~wdata_i;
    end
    evt_buf_d = (evt_buf_d | event_lines_i) & clear_mask_i;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      evt_mask_q   <= '0;
      irq_mask_q   <= '0;
      evt_buf_q    <= '0;
      clr_masked_q <= 1'b0;
    end else begin
      evt_mask_q   <= evt_mask_d;
      irq_mask_q   <= irq_mask_d;
      evt_buf_q    <= evt_buf_d;
      // clear lands one cycle after the granted wait_clear read
      clr_masked_q <= clr_masked_i;
    end
  end

  assign evt_mask_o       = evt_mask_q;
  assign irq_mask_o       = irq_mask_q;
  assign evt_buf_o        = evt_buf_q;
  assign evt_buf_masked_o = evt_buf_q & evt_mask_q;
  assign evt_pending_o    = |evt_buf_masked_o;

endmodule

`default_nettype wire

//--- source/eu_irq_select.sv
// interrupt masking, highest-index priority select, request gating and acknowledge clear mask
`timescale 1ns/1ps
`default_nettype none

module eu_irq_select #(
  parameter int unsigned NB_EVENTS = 32
) (
  input  wire logic [NB_EVENTS-1:0]         evt_buf_i,
  input  wire logic [NB_EVENTS-1:0]         irq_mask_i,
  input  wire logic                         irq_hold_i,
  input  wire logic                         irq_ack_i,
  input  wire logic [$clog2(NB_EVENTS)-1:0] irq_ack_id_i,
  output logic [NB_EVENTS-1:0]              irq_buf_masked_o,
  output logic                              irq_pending_o,
  output logic                              irq_req_o,
  output logic [$clog2(NB_EVENTS)-1:0]      irq_id_o,
  output logic [NB_EVENTS-1:0]              clear_mask_o
);

  localparam int unsigned ID_W = $clog2(NB_EVENTS);

  logic [NB_EVENTS-1:0] masked;
  logic [ID_W-1:0]      sel_id;
  logic                 req;

  always_comb begin
    masked = evt_buf_i & irq_mask_i;
    // later hits overwrite earlier ones, so the highest set index stays
    sel_id = '0;
    for (int unsigned i = 1; i < NB_EVENTS; i++) begin
      if (masked[i]) begin
        sel_id = ID_W'(i);
      end
    end
    // held back while the core is about to sleep
    req = (|masked) & ~irq_hold_i;

    irq_buf_masked_o = masked;
    irq_pending_o    = |masked;
    irq_req_o        = req;
    irq_id_o         = sel_id;

    a_irq_id_valid : assert (!req || masked[sel_id])
      else $error("irq_id_o %0h points at a clear bit of %0h", sel_id, masked);
  end

  // one-hot clear of the served bit
  assign clear_mask_o = irq_ack_i ? ~(NB_EVENTS'(1) << irq_ack_id_i) : '1;

endmodule

`default_nettype wire

//--- source/eu_pkg.sv
// shared widths, register offsets and FSM states for the event unit, referenced by scoped name
`default_nettype none

package eu_pkg;

  // register data word
  parameter int unsigned DATA_W = 32;

  // word offset on the register port
  parameter int unsigned OFFS_W = 4;

  // register map, one word per offset
  typedef enum logic [OFFS_W-1:0] {
    REG_EVT_MASK       = 4'd0,
    REG_EVT_MASK_CLR   = 4'd1,
    REG_EVT_MASK_SET   = 4'd2,
    REG_IRQ_MASK       = 4'd3,
    REG_IRQ_MASK_CLR   = 4'd4,
    REG_IRQ_MASK_SET   = 4'd5,
    REG_CLK_STATUS     = 4'd6,
    REG_EVT_BUF        = 4'd7,
    REG_EVT_BUF_MASKED = 4'd8,
    REG_IRQ_BUF_MASKED = 4'd9,
    REG_EVT_BUF_CLR    = 4'd10,
    REG_RSVD_11        = 4'd11,
    REG_RSVD_12        = 4'd12,
    REG_RSVD_13        = 4'd13,
    REG_WAIT           = 4'd14,
    REG_WAIT_CLR       = 4'd15
  } eu_reg_e;

  // core clock gating states
  typedef enum logic [2:0] {
    ACTIVE,
    SLEEP,
    WAKEUP_SLEEP,
    WAKEUP_SLEEP_DEL,
    WAKEUP_IRQ,
    IRQ_WHILE_SLEEP
  } clk_state_e;

endpackage

`default_nettype wire

//--- source/eu_reg_port.sv
// register port of the event unit: grant, write decode, sleep request and one-cycle read return
`timescale 1ns/1ps
`default_nettype none

module eu_reg_port #(
  parameter int unsigned NB_EVENTS = 32
) (
  input  wire logic                        clk_i,
  input  wire logic                        rst_ni,
  input  wire logic                        req_i,
  input  wire logic                        wen_i,
  input  wire logic [eu_pkg::OFFS_W-1:0]   addr_i,
  input  wire logic [eu_pkg::DATA_W-1:0]   wdata_i,
  input  wire logic                        stall_i,
  input  wire logic [NB_EVENTS-1:0]        evt_mask_i,
  input  wire logic [NB_EVENTS-1:0]        irq_mask_i,
  input  wire logic [NB_EVENTS-1:0]        evt_buf_i,
  input  wire logic [NB_EVENTS-1:0]        evt_buf_masked_i,
  input  wire logic [NB_EVENTS-1:0]        irq_buf_masked_i,
  input  wire logic                        core_clock_en_i,
  output logic                             gnt_o,
  output logic                             r_valid_o,
  output logic [eu_pkg::DATA_W-1:0]        r_rdata_o,
  output logic                             we_evt_mask_o,
  output logic                             we_irq_mask_o,
  output logic                             we_evt_buf_o,
  output eu_pkg::eu_reg_e                  wr_op_o,
  output logic [NB_EVENTS-1:0]             wdata_o,
  output logic                             sleep_req_o,
  output logic                             wait_clr_o
);

  eu_pkg::eu_reg_e op;
  logic            accept;
  logic            is_wait;
  logic            wr_acc;
  logic            rd_q;
  eu_pkg::eu_reg_e raddr_q;

  assign op      = eu_pkg::eu_reg_e'(addr_i);
  assign gnt_o   = req_i & ~stall_i;
  assign accept  = req_i & gnt_o;
  assign wr_acc  = accept & ~wen_i;
  assign is_wait = (op == eu_pkg::REG_WAIT) || (op == eu_pkg::REG_WAIT_CLR);

  // the FSM sees the sleep request before the grant is decided
  assign sleep_req_o = req_i & wen_i & is_wait;
  assign wait_clr_o  = sleep_req_o & (op == eu_pkg::REG_WAIT_CLR);

  // write strobes, one per register group
  assign we_evt_mask_o = wr_acc & ((op == eu_pkg::REG_EVT_MASK) ||
                                   (op == eu_pkg::REG_EVT_MASK_CLR) ||
                                   (op == eu_pkg::REG_EVT_MASK_SET));
  assign we_irq_mask_o = wr_acc & ((op == eu_pkg::REG_IRQ_MASK) ||
                                   (op == eu_pkg::REG_IRQ_MASK_CLR) ||
                                   (op == eu_pkg::REG_IRQ_MASK_SET));
  assign we_evt_buf_o  = wr_acc & (op == eu_pkg::REG_EVT_BUF_CLR);
  assign wr_op_o       = op;
  assign wdata_o       = wdata_i[NB_EVENTS-1:0];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      r_valid_o <= 1'b0;
      rd_q      <= 1'b0;
    end else begin
      r_valid_o <= accept;
      rd_q      <= accept & wen_i;
    end
  end

  // offset of the accepted read
  always_ff @(posedge clk_i) begin
    if (accept) begin
      raddr_q <= op;
    end
  end

  // read data in the response cycle, zero for writes and unlisted offsets
  always_comb begin
    r_rdata_o = '0;
    if (rd_q) begin
      case (raddr_q)
        eu_pkg::REG_EVT_MASK:       r_rdata_o[NB_EVENTS-1:0] = evt_mask_i;
        eu_pkg::REG_IRQ_MASK:       r_rdata_o[NB_EVENTS-1:0] = irq_mask_i;
        eu_pkg::REG_CLK_STATUS:     r_rdata_o[0] = core_clock_en_i;
        eu_pkg::REG_EVT_BUF:        r_rdata_o[NB_EVENTS-1:0] = evt_buf_i;
        eu_pkg::REG_EVT_BUF_MASKED: r_rdata_o[NB_EVENTS-1:0] = evt_buf_masked_i;
        eu_pkg::REG_IRQ_BUF_MASKED: r_rdata_o[NB_EVENTS-1:0] = irq_buf_masked_i;
        eu_pkg::REG_WAIT,
        eu_pkg::REG_WAIT_CLR:       r_rdata_o[NB_EVENTS-1:0] = evt_buf_masked_i;
        default:                    r_rdata_o = '0;
      endcase
    end
  end

  // every response belongs to a request accepted the cycle before
  a_rvalid_after_accept : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
      r_valid_o |-> $past(req_i && gnt_o)
  );

endmodule

`default_nettype wire

//--- source/event_unit_top.sv
// event unit top level: connects register port, event registers, interrupt select and clock FSM
`timescale 1ns/1ps
`default_nettype none

module event_unit_top #(
  parameter int unsigned NB_EVENTS = 32
) (
  input  wire logic                         clk_i,
  input  wire logic                         rst_ni,
  input  wire logic                         req_i,
  input  wire logic                         wen_i,
  input  wire logic [eu_pkg::OFFS_W-1:0]    addr_i,
  input  wire logic [eu_pkg::DATA_W-1:0]    wdata_i,
  output logic                              gnt_o,
  output logic                              r_valid_o,
  output logic [eu_pkg::DATA_W-1:0]         r_rdata_o,
  input  wire logic [NB_EVENTS-1:0]         event_lines_i,
  output logic                              irq_req_o,
  output logic [$clog2(NB_EVENTS)-1:0]      irq_id_o,
  input  wire logic                         irq_ack_i,
  input  wire logic [$clog2(NB_EVENTS)-1:0] irq_ack_id_i,
  input  wire logic                         core_busy_i,
  output logic                              core_clock_en_o
);

  logic                 stall;
  logic                 we_evt_mask;
  logic                 we_irq_mask;
  logic                 we_evt_buf;
  eu_pkg::eu_reg_e      wr_op;
  logic [NB_EVENTS-1:0] wdata;
  logic                 sleep_req;
  logic                 wait_clr;
  logic [NB_EVENTS-1:0] evt_mask;
  logic [NB_EVENTS-1:0] irq_mask;
  logic [NB_EVENTS-1:0] evt_buf;
  logic [NB_EVENTS-1:0] evt_buf_masked;
  logic [NB_EVENTS-1:0] irq_buf_masked;
  logic [NB_EVENTS-1:0] clear_mask;
  logic                 evt_pending;
  logic                 irq_pending;
  logic                 irq_hold;
  logic                 clr_masked;

  eu_reg_port #(.NB_EVENTS(NB_EVENTS)) u_reg_port (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .req_i            (req_i),
    .wen_i            (wen_i),
    .addr_i           (addr_i),
    .wdata_i          (wdata_i),
    .stall_i          (stall),
    .evt_mask_i       (evt_mask),
    .irq_mask_i       (irq_mask),
    .evt_buf_i        (evt_buf),
    .evt_buf_masked_i (evt_buf_masked),
    .irq_buf_masked_i (irq_buf_masked),
    .core_clock_en_i  (core_clock_en_o),
    .gnt_o            (gnt_o),
    .r_valid_o        (r_valid_o),
    .r_rdata_o        (r_rdata_o),
    .we_evt_mask_o    (we_evt_mask),
    .we_irq_mask_o    (we_irq_mask),
    .we_evt_buf_o     (we_evt_buf),
    .wr_op_o          (wr_op),
    .wdata_o          (wdata),
    .sleep_req_o      (sleep_req),
    .wait_clr_o       (wait_clr)
  );

  eu_event_regs #(.NB_EVENTS(NB_EVENTS)) u_event_regs (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .we_evt_mask_i    (we_evt_mask),
    .we_irq_mask_i    (we_irq_mask),
    .we_evt_buf_i     (we_evt_buf),
    .wr_op_i          (wr_op),
    .wdata_i          (wdata),
    .event_lines_i    (event_lines_i),
    .clr_masked_i     (clr_masked),
    .clear_mask_i     (clear_mask),
    .evt_mask_o       (evt_mask),
    .irq_mask_o       (irq_mask),
    .evt_buf_o        (evt_buf),
    .evt_buf_masked_o (evt_buf_masked),
    .evt_pending_o    (evt_pending)
  );

  eu_irq_select #(.NB_EVENTS(NB_EVENTS)) u_irq_select (
    .evt_buf_i        (evt_buf),
    .irq_mask_i       (irq_mask),
    .irq_hold_i       (irq_hold),
    .irq_ack_i        (irq_ack_i),
    .irq_ack_id_i     (irq_ack_id_i),
    .irq_buf_masked_o (irq_buf_masked),
    .irq_pending_o    (irq_pending),
    .irq_req_o        (irq_req_o),
    .irq_id_o         (irq_id_o),
    .clear_mask_o     (clear_mask)
  );

  eu_clock_fsm u_clock_fsm (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .sleep_req_i     (sleep_req),
    .wait_clr_i      (wait_clr),
    .evt_pending_i   (evt_pending),
    .irq_pending_i   (irq_pending),
    .irq_req_i       (irq_req_o),
    .core_busy_i     (core_busy_i),
    .stall_o         (stall),
    .core_clock_en_o (core_clock_en_o),
    .clr_masked_o    (clr_masked),
    .irq_hold_o      (irq_hold)
  );

endmodule

`default_nettype wire
